//--- Bender.yml
package:
  name: pfx_adder

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pfx_arith_pkg.sv
      - rtl/pfx_bus_pkg.sv
      - rtl/pfx_pg_tree.sv
      - rtl/pfx_adder_core.sv
      - rtl/pfx_axil_regs.sv
      - rtl/pfx_adder_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_pfx_adder.sv

//--- rtl/pfx_adder_core.sv
/*
  Add/subtract core around the prefix network, one register stage deep.
  A request presented with i_req_valid returns its sum and flags on the next
  cycle with o_res_valid. It never stalls, so one request per cycle is fine.
*/
`include "pfx_config.svh"

module pfx_adder_core
(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_req_valid,
  input  pfx_arith_pkg::arith_req_t i_req,
  output logic                      o_res_valid,
  output pfx_arith_pkg::arith_res_t o_res
);

  localparam int WIDTH = `PFX_WIDTH;

  pfx_arith_pkg::operand_t   b_eff;
  pfx_arith_pkg::operand_t   bit_p;
  pfx_arith_pkg::operand_t   bit_g;
  pfx_arith_pkg::operand_t   tree_g;
  pfx_arith_pkg::operand_t   carries;
  pfx_arith_pkg::arith_res_t res_d;
  logic                      cin;

  // subtraction is a + ~b + 1, the requested carry-in only applies to adds
  always_comb
  begin
    if (i_req.op == pfx_arith_pkg::OP_SUB)
    begin
      b_eff = ~i_req.b;
      cin   = 1'b1;
    end
    else
    begin
      b_eff = i_req.b;
      cin   = i_req.cin;
    end
  end

  assign bit_p = i_req.a ^ b_eff;

  // carry-in folds into bit 0 so the tree output is already the true carry chain
  assign bit_g[0]         = (i_req.a[0] & b_eff[0]) | (bit_p[0] & cin);
  assign bit_g[WIDTH-1:1] = i_req.a[WIDTH-1:1] & b_eff[WIDTH-1:1];

  pfx_pg_tree u_pg_tree
  (
    .i_p (bit_p),
    .i_g (bit_g),
    .o_g (tree_g)
  );

  // tree_g[i] is the carry out of bit i, so the carry into bit i is one place lower
  assign carries = {tree_g[WIDTH-2:0], cin};

  always_comb
  begin
    res_d.sum = bit_p ^ carries;
    // for a subtract a high carry-out means no borrow
    // overflow is set when the carries into and out of the sign bit differ
    res_d.flags = {tree_g[WIDTH-1], tree_g[WIDTH-1] ^ tree_g[WIDTH-2], ~|res_d.sum};
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_res_valid <= 1'b0;
    end
    else
    begin
      o_res_valid <= i_req_valid;
    end
  end

  // result word only moves when a request is presented
  always_ff @(posedge i_clk)
  begin
    if (i_req_valid)
    begin
      o_res <= res_d;
    end
  end

endmodule

//--- rtl/pfx_adder_top.sv
/*
  Top level of the prefix adder unit.
  Software drives it over AXI4-Lite, the register slave feeds the adder core.
*/
module pfx_adder_top
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  pfx_bus_pkg::axi_addr_t i_awaddr,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  input  pfx_bus_pkg::axi_data_t i_wdata,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  output pfx_bus_pkg::axi_resp_t o_bresp,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  input  pfx_bus_pkg::axi_addr_t i_araddr,
  output logic                   o_rvalid,
  input  logic                   i_rready,
  output pfx_bus_pkg::axi_data_t o_rdata,
  output pfx_bus_pkg::axi_resp_t o_rresp
);

  // request and result path between the slave and the core
  logic                      req_valid;
  pfx_arith_pkg::arith_req_t req;
  logic                      res_valid;
  pfx_arith_pkg::arith_res_t res;

  pfx_axil_regs u_regs
  (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_awaddr    (i_awaddr),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .i_wdata     (i_wdata),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .o_bresp     (o_bresp),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .i_araddr    (i_araddr),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_req_valid (req_valid),
    .o_req       (req),
    .i_res_valid (res_valid),
    .i_res       (res)
  );

  pfx_adder_core u_core
  (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_res_valid (res_valid),
    .o_res       (res)
  );

endmodule

//--- rtl/pfx_arith_pkg.sv
/*
  Datapath types shared by the register slave and the adder core.
  The request and result structs carry one operation across the boundary.
*/
`include "pfx_config.svh"

package pfx_arith_pkg;

  // one operand or sum word
  typedef logic [`PFX_WIDTH-1:0] operand_t;

  // bit 2 is carry-out, bit 1 is signed overflow, bit 0 is zero
  typedef logic [2:0] flags_t;

  // selected by bit 0 of the CTRL register
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } arith_op_e;

  // one operation handed to the core, carry-in is ignored for OP_SUB
  typedef struct packed {
    arith_op_e op;
    logic      cin;
    operand_t  a;
    operand_t  b;
  } arith_req_t;

  // what the core returns one cycle later
  typedef struct packed {
    operand_t sum;
    flags_t   flags;
  } arith_res_t;

endpackage

//--- rtl/pfx_axil_regs.sv
/*
  AXI4-Lite register slave in front of the adder core.
  Holds OP_A, OP_B and CTRL. A CTRL write issues one request to the core and
  the returned result lands in RESULT and STATUS. One write and one read can
  be outstanding at a time, and bad offsets answer with SLVERR.
*/
`include "pfx_config.svh"

module pfx_axil_regs
(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  pfx_bus_pkg::axi_addr_t    i_awaddr,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  input  pfx_bus_pkg::axi_data_t    i_wdata,
  output logic                      o_bvalid,
  input  logic                      i_bready,
  output pfx_bus_pkg::axi_resp_t    o_bresp,
  input  logic                      i_arvalid,
  output logic                      o_arready,
  input  pfx_bus_pkg::axi_addr_t    i_araddr,
  output logic                      o_rvalid,
  input  logic                      i_rready,
  output pfx_bus_pkg::axi_data_t    o_rdata,
  output pfx_bus_pkg::axi_resp_t    o_rresp,
  output logic                      o_req_valid,
  output pfx_arith_pkg::arith_req_t o_req,
  input  logic                      i_res_valid,
  input  pfx_arith_pkg::arith_res_t i_res
);

  pfx_bus_pkg::wr_state_e     wr_state_q;
  pfx_bus_pkg::rd_state_e     rd_state_q;
  logic                       wr_hs;
  logic                       rd_hs;
  logic                       wr_ok;
  pfx_bus_pkg::axi_data_t     rd_data_d;
  pfx_bus_pkg::axi_resp_t     rd_resp_d;
  pfx_arith_pkg::operand_t    op_a_q;
  pfx_arith_pkg::operand_t    op_b_q;
  pfx_arith_pkg::operand_t    result_q;
  pfx_arith_pkg::arith_op_e   op_q;
  logic                       cin_q;
  logic                       busy_q;
  logic                       done_q;
  pfx_arith_pkg::flags_t      flags_q;

  // address and data are taken together in a single cycle, and only when idle
  assign o_awready = (wr_state_q == pfx_bus_pkg::W_IDLE) && i_awvalid && i_wvalid;
  assign o_wready  = o_awready;
  assign wr_hs     = o_awready;
  assign o_bvalid  = (wr_state_q == pfx_bus_pkg::W_RESP);

  // STATUS and RESULT are read only
  always_comb
  begin
    case (i_awaddr)
      `PFX_ADDR_OP_A, `PFX_ADDR_OP_B, `PFX_ADDR_CTRL: wr_ok = 1'b1;
      default:                                        wr_ok = 1'b0;
    endcase
  end

  assign o_arready = (rd_state_q == pfx_bus_pkg::R_IDLE) && i_arvalid;
  assign rd_hs     = o_arready;
  assign o_rvalid  = (rd_state_q == pfx_bus_pkg::R_DATA);

  // STATUS layout is busy in bit 0, done in bit 1 and the flags in bits 6..4
  always_comb
  begin
    rd_resp_d = `PFX_RESP_OKAY;
    case (i_araddr)
      `PFX_ADDR_OP_A:   rd_data_d = op_a_q;
      `PFX_ADDR_OP_B:   rd_data_d = op_b_q;
      `PFX_ADDR_CTRL:   rd_data_d = {30'b0, cin_q, op_q};
      `PFX_ADDR_STATUS: rd_data_d = {25'b0, flags_q, 2'b0, done_q, busy_q};
      `PFX_ADDR_RESULT: rd_data_d = result_q;
      default:
      begin
        rd_data_d = '0;
        rd_resp_d = `PFX_RESP_SLVERR;
      end
    endcase
  end

  // both channel FSMs, the response stays up until the master takes it
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      wr_state_q <= pfx_bus_pkg::W_IDLE;
      rd_state_q <= pfx_bus_pkg::R_IDLE;
    end
    else
    begin
      if (wr_hs)
        wr_state_q <= pfx_bus_pkg::W_RESP;
      else if (o_bvalid && i_bready)
        wr_state_q <= pfx_bus_pkg::W_IDLE;
      if (rd_hs)
        rd_state_q <= pfx_bus_pkg::R_DATA;
      else if (o_rvalid && i_rready)
        rd_state_q <= pfx_bus_pkg::R_IDLE;
    end
  end

  // response payloads are sampled on the handshake and held while stalled
  always_ff @(posedge i_clk)
  begin
    if (wr_hs)
      o_bresp <= wr_ok ? `PFX_RESP_OKAY : `PFX_RESP_SLVERR;
    if (rd_hs)
    begin
      o_rdata <= rd_data_d;
      o_rresp <= rd_resp_d;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      op_q        <= pfx_arith_pkg::OP_ADD;
      cin_q       <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      flags_q     <= '0;
      o_req_valid <= 1'b0;
    end
    else
    begin
      o_req_valid <= 1'b0;
      if (i_res_valid)
      begin
        busy_q  <= 1'b0;
        done_q  <= 1'b1;
        flags_q <= i_res.flags;
      end
      // a new CTRL write takes priority over a result landing in the same cycle
      if (wr_hs && (i_awaddr == `PFX_ADDR_CTRL))
      begin
        op_q        <= pfx_arith_pkg::arith_op_e'(i_wdata[0]);
        cin_q       <= i_wdata[1];
        busy_q      <= 1'b1;
        done_q      <= 1'b0;
        o_req_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (wr_hs && (i_awaddr == `PFX_ADDR_OP_A))
      op_a_q <= i_wdata;
    if (wr_hs && (i_awaddr == `PFX_ADDR_OP_B))
      op_b_q <= i_wdata;
    if (i_res_valid)
      result_q <= i_res.sum;
  end

  // the request is built straight from the registers, valid for the cycle after CTRL
  always_comb
  begin
    o_req.op  = op_q;
    o_req.cin = cin_q;
    o_req.a   = op_a_q;
    o_req.b   = op_b_q;
  end

endmodule

//--- rtl/pfx_bus_pkg.sv
/*
  Bus-side types for the AXI4-Lite register slave.
  Covers the address, data and response vectors and the two channel FSM encodings.
*/
package pfx_bus_pkg;

  // byte address inside the register window
  typedef logic [7:0] axi_addr_t;

  // every access is a full 32-bit word, there are no write strobes
  typedef logic [31:0] axi_data_t;

  // OKAY or SLVERR, see the config header
  typedef logic [1:0] axi_resp_t;

  // write channel FSM
  // W_IDLE waits for address and data together, W_RESP holds bvalid until bready
  typedef enum logic {
    W_IDLE = 1'b0,
    W_RESP = 1'b1
  } wr_state_e;

  // read channel FSM
  // R_IDLE waits for arvalid, R_DATA holds rvalid until rready
  typedef enum logic {
    R_IDLE = 1'b0,
    R_DATA = 1'b1
  } rd_state_e;

endpackage

//--- rtl/pfx_config.svh
/*
  Build-wide constants for the prefix adder unit.
  Holds the operand width, the AXI4-Lite register map and the response codes.
  Include it in any file that needs one of these values.
*/
`ifndef PFX_CONFIG_SVH
`define PFX_CONFIG_SVH

// operand, sum and register width in bits
`define PFX_WIDTH 32

// register byte offsets on the AXI4-Lite slave
`define PFX_ADDR_OP_A   8'h00
`define PFX_ADDR_OP_B   8'h04
`define PFX_ADDR_CTRL   8'h08
`define PFX_ADDR_STATUS 8'h0C
`define PFX_ADDR_RESULT 8'h10

// AXI response codes used by the slave
`define PFX_RESP_OKAY   2'b00
`define PFX_RESP_SLVERR 2'b10

`endif

//--- rtl/pfx_pg_tree.sv
/*
  Sklansky parallel-prefix network over bit propagate/generate pairs.
  Produces the group generate from bit 0 up to every bit, which the adder
  core uses directly as the carry out of that bit. Purely combinational.
*/
`include "pfx_config.svh"

module pfx_pg_tree
(
  input  pfx_arith_pkg::operand_t i_p,
  input  pfx_arith_pkg::operand_t i_g,
  output pfx_arith_pkg::operand_t o_g
);

  localparam int WIDTH  = `PFX_WIDTH;
  localparam int LEVELS = $clog2(WIDTH);

  // row 0 is the input pairs, row LEVELS holds the finished prefixes
  logic [LEVELS:0][WIDTH-1:0] p_lvl;
  logic [LEVELS:0][WIDTH-1:0] g_lvl;

  assign p_lvl[0] = i_p;
  assign g_lvl[0] = i_g;

  // at level l the bits fall into blocks of 2^(l+1)
  // every bit in the upper half of a block combines with the top bit of the lower half
  for (genvar l = 0; l < LEVELS; l++)
  begin : g_level
    for (genvar i = 0; i < WIDTH; i++)
    begin : g_bit
      if (((i >> l) & 1) == 1)
      begin : g_comb
        // lsb side of the node, the last bit of the lower half
        localparam int LSB = ((i >> l) << l) - 1;
        if (i < (2 << l))
        begin : g_grey
          // span now reaches bit 0, so only the generate is needed from here on
          // the group propagate is never read again and is tied low
          assign g_lvl[l+1][i] = g_lvl[l][i] | (g_lvl[l][LSB] & p_lvl[l][i]);
          assign p_lvl[l+1][i] = 1'b0;
        end
        else
        begin : g_black
          // msb side generate wins, otherwise the lsb generate passes if msb propagates
          assign g_lvl[l+1][i] = g_lvl[l][i] | (g_lvl[l][LSB] & p_lvl[l][i]);
          assign p_lvl[l+1][i] = p_lvl[l][i] & p_lvl[l][LSB];
        end
      end
      else
      begin : g_buf
        // lower half of the block is already complete at this level
        assign p_lvl[l+1][i] = p_lvl[l][i];
        assign g_lvl[l+1][i] = g_lvl[l][i];
      end
    end
  end

  assign o_g = g_lvl[LEVELS];

endmodule

//--- tb/pfx_patterns.txt
# columns in hex: op (0 add, 1 sub), carry-in, operand a, operand b, expected sum, expected flags
# flags are carry-out in bit 2, signed overflow in bit 1, zero in bit 0
0 0 00000001 00000002 00000003 0
0 1 ffffffff 00000000 00000000 5
0 0 7fffffff 00000001 80000000 2
0 0 80000000 80000000 00000000 7
0 0 12345678 9abcdef0 acf13568 0
0 1 0000ffff 00000001 00010001 0
0 1 ffffffff ffffffff ffffffff 4
1 0 00000005 00000003 00000002 4
1 0 00000003 00000005 fffffffe 0
1 0 12345678 12345678 00000000 5
1 0 80000000 00000001 7fffffff 6
1 0 7fffffff ffffffff 80000000 2
1 1 00000000 00000000 00000000 5
1 0 00000000 00000001 ffffffff 0

//--- tb/tb_clk_gen.sv
/*
  Free-running testbench clock with a period of 10 time units.
*/
module tb_clk_gen
(
  output logic o_clk
);

  // starts low so the first rising edge lands at 5
  initial
  begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

endmodule

//--- tb/tb_pfx_adder.sv
/*
  Testbench for the AXI4-Lite prefix adder unit.
  Reads operations and expected results from the pattern file, runs each one
  through the register map and checks RESULT, STATUS and every bus response.
*/
`include "pfx_config.svh"

module tb_pfx_adder;

  localparam int TIMEOUT    = 100;
  localparam int POLL_LIMIT = 16;

  logic                   clk;
  logic                   rst_n;
  logic                   awvalid;
  logic                   awready;
  pfx_bus_pkg::axi_addr_t awaddr;
  logic                   wvalid;
  logic                   wready;
  pfx_bus_pkg::axi_data_t wdata;
  logic                   bvalid;
  logic                   bready;
  pfx_bus_pkg::axi_resp_t bresp;
  logic                   arvalid;
  logic                   arready;
  pfx_bus_pkg::axi_addr_t araddr;
  logic                   rvalid;
  logic                   rready;
  pfx_bus_pkg::axi_data_t rdata;
  pfx_bus_pkg::axi_resp_t rresp;

  logic [31:0]            lfsr;
  pfx_bus_pkg::axi_data_t rd;
  pfx_bus_pkg::axi_resp_t rs;
  logic [31:0]            f_op;
  logic [31:0]            f_cin;
  logic [31:0]            f_a;
  logic [31:0]            f_b;
  logic [31:0]            f_sum;
  logic [31:0]            f_flags;
  logic [31:0]            last_sum;
  logic [2:0]             last_flags;
  string                  line;
  int                     fd;
  int                     code;
  int                     npat;

  tb_clk_gen u_clk_gen
  (
    .o_clk (clk)
  );

  pfx_adder_top uut
  (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1 whose new bit enters at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // two LFSR bits give a stall of 0 to 3 cycles and each bit costs one step
  task automatic random_stall(output int n);
    n = 0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      n    = (n << 1) | lfsr[0];
    end
  endtask

  task automatic check_data(input string name, input pfx_bus_pkg::axi_data_t got,
                            input pfx_bus_pkg::axi_data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Fail %s: got %08h, expected %08h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input pfx_bus_pkg::axi_resp_t got,
                            input pfx_bus_pkg::axi_resp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Fail %s: got %0h, expected %0h", name, got, exp));
  endtask

  // address and data go out together and bready is then held back for a while
  task automatic axi_write(input pfx_bus_pkg::axi_addr_t addr,
                           input pfx_bus_pkg::axi_data_t data,
                           input pfx_bus_pkg::axi_resp_t exp_resp);
    int                     cnt;
    int                     n;
    pfx_bus_pkg::axi_resp_t first;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    cnt = 0;
    @(negedge clk);
    while (!(awready && wready))
    begin
      cnt++;
      if (cnt > TIMEOUT)
        stop_on_error("awready and wready never rose together for a write");
      @(negedge clk);
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!bvalid)
    begin
      cnt++;
      if (cnt > TIMEOUT)
        stop_on_error("bvalid never rose after a write");
      @(negedge clk);
    end
    first = bresp;
    random_stall(n);
    repeat (n) @(posedge clk);
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    if (!bvalid)
      stop_on_error("bvalid dropped before bready was given");
    // the response must not move while the master stalls
    check_resp("bresp", bresp, first);
    check_resp("bresp", bresp, exp_resp);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input pfx_bus_pkg::axi_addr_t addr,
                          output pfx_bus_pkg::axi_data_t data,
                          output pfx_bus_pkg::axi_resp_t resp);
    int                     cnt;
    int                     n;
    pfx_bus_pkg::axi_data_t first_data;
    pfx_bus_pkg::axi_resp_t first_resp;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    cnt = 0;
    @(negedge clk);
    while (!arready)
    begin
      cnt++;
      if (cnt > TIMEOUT)
        stop_on_error("arready never rose for a read");
      @(negedge clk);
    end
    @(posedge clk);
    arvalid <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!rvalid)
    begin
      cnt++;
      if (cnt > TIMEOUT)
        stop_on_error("rvalid never rose after a read");
      @(negedge clk);
    end
    first_data = rdata;
    first_resp = rresp;
    random_stall(n);
    repeat (n) @(posedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    if (!rvalid)
      stop_on_error("rvalid dropped before rready was given");
    check_data("rdata", rdata, first_data);
    check_resp("rresp", rresp, first_resp);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // reads STATUS until done is set and returns the last value read
  task automatic poll_done(output pfx_bus_pkg::axi_data_t status);
    int                     polls;
    pfx_bus_pkg::axi_resp_t resp;
    polls = 0;
    axi_read(`PFX_ADDR_STATUS, status, resp);
    while (!status[1])
    begin
      polls++;
      if (polls > POLL_LIMIT)
        stop_on_error("STATUS.done never came up after a CTRL write");
      axi_read(`PFX_ADDR_STATUS, status, resp);
    end
    check_resp("rresp", resp, `PFX_RESP_OKAY);
  endtask

  task automatic run_pattern(input logic op, input logic cin, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] sum,
                             input logic [2:0] flags, input logic [2:0] prev_flags);
    pfx_bus_pkg::axi_data_t data;
    pfx_bus_pkg::axi_resp_t resp;
    pfx_bus_pkg::axi_data_t mid_data;
    pfx_bus_pkg::axi_resp_t mid_resp;
    axi_write(`PFX_ADDR_OP_A, a, `PFX_RESP_OKAY);
    axi_write(`PFX_ADDR_OP_B, b, `PFX_RESP_OKAY);
    // operands read back unchanged
    axi_read(`PFX_ADDR_OP_A, data, resp);
    check_data("OP_A", data, a);
    check_resp("rresp", resp, `PFX_RESP_OKAY);
    axi_read(`PFX_ADDR_OP_B, data, resp);
    check_data("OP_B", data, b);
    check_resp("rresp", resp, `PFX_RESP_OKAY);
    // bit 0 selects subtract and bit 1 is the carry-in, and the write starts the unit
    // a STATUS read one cycle behind the CTRL write is taken while the request is in flight
    // so it sees busy set, done cleared and the flags of the previous result
    fork
      axi_write(`PFX_ADDR_CTRL, {30'b0, cin, op}, `PFX_RESP_OKAY);
      begin
        @(posedge clk);
        axi_read(`PFX_ADDR_STATUS, mid_data, mid_resp);
      end
    join
    check_data("STATUS", mid_data, {25'b0, prev_flags, 2'b00, 1'b0, 1'b1});
    check_resp("rresp", mid_resp, `PFX_RESP_OKAY);
    axi_read(`PFX_ADDR_CTRL, data, resp);
    check_data("CTRL", data, {30'b0, cin, op});
    check_resp("rresp", resp, `PFX_RESP_OKAY);
    poll_done(data);
    // done is set and busy is clear with the flags in bits 6..4
    check_data("STATUS", data, {25'b0, flags, 2'b00, 1'b1, 1'b0});
    axi_read(`PFX_ADDR_RESULT, data, resp);
    check_data("RESULT", data, sum);
    check_resp("rresp", resp, `PFX_RESP_OKAY);
  endtask

  initial
  begin
    rst_n      = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    lfsr       = 32'h2e79;
    last_flags = 3'b000;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // STATUS comes out of reset as zero
    axi_read(`PFX_ADDR_STATUS, rd, rs);
    check_data("STATUS", rd, 32'h0);
    check_resp("rresp", rs, `PFX_RESP_OKAY);

    fd = $fopen("tb/pfx_patterns.txt", "r");
    if (fd == 0)
      stop_on_error("could not open tb/pfx_patterns.txt");
    npat = 0;
    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      // comment and blank lines do not scan as six fields and are skipped
      if (code > 0)
      begin
        if ($sscanf(line, "%h %h %h %h %h %h", f_op, f_cin, f_a, f_b, f_sum, f_flags) == 6)
        begin
          run_pattern(f_op[0], f_cin[0], f_a, f_b, f_sum, f_flags[2:0], last_flags);
          last_sum   = f_sum;
          last_flags = f_flags[2:0];
          npat++;
        end
      end
    end
    $fclose(fd);
    if (npat == 0)
      stop_on_error("no patterns were read from the pattern file");

    // read-only registers and holes in the map answer SLVERR
    axi_write(`PFX_ADDR_STATUS, 32'hdead_beef, `PFX_RESP_SLVERR);
    axi_write(`PFX_ADDR_RESULT, 32'h0bad_cafe, `PFX_RESP_SLVERR);
    axi_read(8'h14, rd, rs);
    check_resp("rresp", rs, `PFX_RESP_SLVERR);
    axi_read(8'h40, rd, rs);
    check_resp("rresp", rs, `PFX_RESP_SLVERR);
    axi_read(`PFX_ADDR_RESULT, rd, rs);
    check_data("RESULT", rd, last_sum);
    check_resp("rresp", rs, `PFX_RESP_OKAY);

    $display("all tests passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+rtl
rtl/pfx_arith_pkg.sv
rtl/pfx_bus_pkg.sv
rtl/pfx_pg_tree.sv
rtl/pfx_adder_core.sv
rtl/pfx_axil_regs.sv
rtl/pfx_adder_top.sv
tb/tb_clk_gen.sv
tb/tb_pfx_adder.sv
